// File: logic/hci_pkg.sv
// Shared types, queue depths and register map of the PIO queue block; imported by every RTL module
package hci_pkg;

  // Widths that carry a meaning
  typedef logic [31:0] csr_data_t;   // Software data word
  typedef logic [63:0] cmd_data_t;   // First dword written sits in the low half
  typedef logic [31:0] resp_data_t;
  typedef logic [7:0]  thld_t;
  typedef logic [3:0]  csr_addr_t;

  // Queue depths in entries
  localparam int unsigned CmdDepth  = 8;
  localparam int unsigned RespDepth = 16;

  // Counts run from 0 up to the full depth
  typedef logic [3:0] cmd_depth_t;
  typedef logic [4:0] resp_depth_t;

  // Register map
  localparam csr_addr_t AddrCmdPort     = 4'd0;  // Write only
  localparam csr_addr_t AddrRespPort    = 4'd1;  // Read pops the head
  localparam csr_addr_t AddrThldCtrl    = 4'd2;
  localparam csr_addr_t AddrResetCtrl   = 4'd3;
  localparam csr_addr_t AddrQueueStatus = 4'd4;

  // Thld ctrl fields
  localparam int unsigned CmdThldLsb  = 0;
  localparam int unsigned RespThldLsb = 8;

  // Reset ctrl bits
  localparam int unsigned CmdRstBit  = 0;
  localparam int unsigned RespRstBit = 1;

  // Queue status fields
  localparam int unsigned CmdDepthLsb  = 0;
  localparam int unsigned RespDepthLsb = 8;

  // Software request, strobes are single cycle with no back-pressure
  typedef struct packed {
    logic      we;
    logic      re;
    csr_addr_t addr;
    csr_data_t wdata;
  } csr_req_t;

  // Answer comes one cycle after the strobe
  typedef struct packed {
    logic      ack;
    csr_data_t rdata;
  } csr_rsp_t;

  // Dword pairing state of the command port
  typedef enum logic {
    CMD_LOW,
    CMD_HIGH
  } cmd_asm_e;

endpackage

// File: logic/hci_fifo.sv
// Show-ahead synchronous FIFO with depth count and synchronous flush; used by both PIO queues
`timescale 1ns/10ps

module hci_fifo #(
  parameter int unsigned Depth = 8,  // Power of two, pointers wrap on overflow
  parameter int unsigned Width = 32
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       push_i,
  input  logic [Width-1:0]           wdata_i,
  input  logic                       pop_i,
  output logic [Width-1:0]           rdata_o,
  input  logic                       flush_i,
  output logic [$clog2(Depth+1)-1:0] count_o,
  output logic                       full_o,
  output logic                       empty_o
);

  logic [Width-1:0]           mem_q [Depth];
  logic [$clog2(Depth)-1:0]   wr_ptr_q;
  logic [$clog2(Depth)-1:0]   rd_ptr_q;
  logic [$clog2(Depth+1)-1:0] count_q;
  logic                       do_push;
  logic                       do_pop;

  assign full_o  = (count_q == Depth);
  assign empty_o = (count_q == '0);
  assign count_o = count_q;

  // Flush wins over both push and pop
  assign do_push = push_i & ~full_o & ~flush_i;
  assign do_pop  = pop_i & ~empty_o & ~flush_i;

  // Head entry visible without delay
  assign rdata_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Simultaneous push and pop leaves the count alone
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (flush_i) begin
      count_q <= '0;
    end else if (do_push && !do_pop) begin
      count_q <= count_q + 1'b1;
    end else if (do_pop && !do_push) begin
      count_q <= count_q - 1'b1;
    end
  end

endmodule

// File: logic/hci_cmd_queue.sv
// Command queue; pairs software dwords into 64-bit commands and feeds them to the controller
`timescale 1ns/10ps

module hci_cmd_queue (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                dword_wr_i,
  input  hci_pkg::csr_data_t  dword_i,
  input  hci_pkg::thld_t      thld_i,
  input  logic                flush_i,
  output logic                flush_done_o,
  output logic                rvalid_o,
  input  logic                ready_i,
  output hci_pkg::cmd_data_t  rdata_o,
  output hci_pkg::cmd_depth_t depth_o,
  output logic                thld_trig_o
);

  import hci_pkg::*;

  cmd_asm_e   asm_state_q;
  csr_data_t  low_dword_q;
  cmd_data_t  entry_q;
  logic       push_q;
  logic       flush_done_q;
  logic       fifo_flush;
  logic       full;
  logic       empty;
  cmd_depth_t free_entries;
  thld_t      eff_thld;

  // Only one flush cycle per request
  assign fifo_flush   = flush_i & ~flush_done_q;
  assign flush_done_o = flush_done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      asm_state_q  <= CMD_LOW;
      push_q       <= 1'b0;
      flush_done_q <= 1'b0;
    end else begin
      flush_done_q <= fifo_flush;
      push_q       <= 1'b0;
      if (fifo_flush) begin
        asm_state_q <= CMD_LOW;  // Half-built pair is discarded
      end else if (dword_wr_i) begin
        if (asm_state_q == CMD_LOW) begin
          asm_state_q <= CMD_HIGH;
        end else begin
          asm_state_q <= CMD_LOW;
          push_q      <= ~full;  // Full queue drops the command
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (dword_wr_i && asm_state_q == CMD_LOW) begin
      low_dword_q <= dword_i;
    end
    if (dword_wr_i && asm_state_q == CMD_HIGH) begin
      entry_q <= {dword_i, low_dword_q};
    end
  end

  hci_fifo #(
    .Depth(CmdDepth),
    .Width($bits(cmd_data_t))
  ) cmd_fifo_i (
    .clk_i,
    .rst_ni,
    .push_i (push_q),
    .wdata_i(entry_q),
    .pop_i  (rvalid_o & ready_i),
    .rdata_o,
    .flush_i(fifo_flush),
    .count_o(depth_o),
    .full_o (full),
    .empty_o(empty)
  );

  assign rvalid_o = ~empty;

  // Trigger on free space, threshold 0 behaves as 1
  assign free_entries = cmd_depth_t'(CmdDepth) - depth_o;
  assign eff_thld     = (thld_i == '0) ? thld_t'(1) : thld_i;
  assign thld_trig_o  = thld_t'(free_entries) >= eff_thld;

endmodule

// File: logic/hci_resp_queue.sv
// Response queue; buffers controller responses until software reads them from the response port
`timescale 1ns/10ps

module hci_resp_queue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 wvalid_i,
  output logic                 wready_o,
  input  hci_pkg::resp_data_t  wdata_i,
  input  logic                 pop_i,
  output hci_pkg::resp_data_t  head_o,
  input  hci_pkg::thld_t       thld_i,
  input  logic                 flush_i,
  output logic                 flush_done_o,
  output hci_pkg::resp_depth_t depth_o,
  output logic                 thld_trig_o
);

  import hci_pkg::*;

  logic  flush_done_q;
  logic  fifo_flush;
  logic  full;
  thld_t eff_thld;

  assign fifo_flush   = flush_i & ~flush_done_q;
  assign flush_done_o = flush_done_q;

  // Done pulses on the cycle after the queue emptied
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_done_q <= 1'b0;
    end else begin
      flush_done_q <= fifo_flush;
    end
  end

  assign wready_o = ~full;

  hci_fifo #(
    .Depth(RespDepth),
    .Width($bits(resp_data_t))
  ) resp_fifo_i (
    .clk_i,
    .rst_ni,
    .push_i (wvalid_i & wready_o),
    .wdata_i,
    .pop_i,                 // Already gated on empty by the register block
    .rdata_o(head_o),
    .flush_i(fifo_flush),
    .count_o(depth_o),
    .full_o (full),
    .empty_o()
  );

  // Fill level against effective threshold
  assign eff_thld    = (thld_i == '0) ? thld_t'(1) : thld_i;
  assign thld_trig_o = thld_t'(depth_o) >= eff_thld;

endmodule

// File: logic/hci_pio_regs.sv
// Software register port of the PIO block; decodes strobes, holds thresholds and queue resets
`timescale 1ns/10ps

module hci_pio_regs (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  hci_pkg::csr_req_t    csr_req_i,
  output hci_pkg::csr_rsp_t    csr_rsp_o,
  output logic                 cmd_dword_wr_o,
  output hci_pkg::csr_data_t   cmd_dword_o,
  output logic                 resp_pop_o,
  input  hci_pkg::resp_data_t  resp_head_i,
  input  hci_pkg::cmd_depth_t  cmd_depth_i,
  input  hci_pkg::resp_depth_t resp_depth_i,
  output hci_pkg::thld_t       cmd_thld_o,
  output hci_pkg::thld_t       resp_thld_o,
  output logic                 cmd_flush_o,
  output logic                 resp_flush_o,
  input  logic                 cmd_flush_done_i,
  input  logic                 resp_flush_done_i
);

  import hci_pkg::*;

  logic      thld_wr;
  logic      rst_wr;
  logic      ack_q;
  csr_data_t rdata_q;
  csr_data_t rdata_d;
  thld_t     cmd_thld_q;
  thld_t     resp_thld_q;
  logic      cmd_rst_q;
  logic      resp_rst_q;

  assign cmd_dword_wr_o = csr_req_i.we && csr_req_i.addr == AddrCmdPort;
  assign cmd_dword_o    = csr_req_i.wdata;
  assign thld_wr        = csr_req_i.we && csr_req_i.addr == AddrThldCtrl;
  assign rst_wr         = csr_req_i.we && csr_req_i.addr == AddrResetCtrl;

  // No pop from an empty queue
  assign resp_pop_o = csr_req_i.re && csr_req_i.addr == AddrRespPort && resp_depth_i != '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_thld_q  <= thld_t'(1);
      resp_thld_q <= thld_t'(1);
    end else if (thld_wr) begin
      cmd_thld_q  <= csr_req_i.wdata[CmdThldLsb+:$bits(thld_t)];
      resp_thld_q <= csr_req_i.wdata[RespThldLsb+:$bits(thld_t)];
    end
  end

  // Reset bits stay set until the queue reports the flush done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_rst_q  <= 1'b0;
      resp_rst_q <= 1'b0;
    end else begin
      if (rst_wr && csr_req_i.wdata[CmdRstBit]) begin
        cmd_rst_q <= 1'b1;
      end else if (cmd_flush_done_i) begin
        cmd_rst_q <= 1'b0;
      end
      if (rst_wr && csr_req_i.wdata[RespRstBit]) begin
        resp_rst_q <= 1'b1;
      end else if (resp_flush_done_i) begin
        resp_rst_q <= 1'b0;
      end
    end
  end

  assign cmd_thld_o   = cmd_thld_q;
  assign resp_thld_o  = resp_thld_q;
  assign cmd_flush_o  = cmd_rst_q;
  assign resp_flush_o = resp_rst_q;

  // Read-back mux, command port and unknown addresses read as zero
  always_comb begin
    rdata_d = '0;
    case (csr_req_i.addr)
      AddrRespPort: rdata_d = resp_pop_o ? resp_head_i : '0;
      AddrThldCtrl: begin
        rdata_d[CmdThldLsb+:$bits(thld_t)]  = cmd_thld_q;
        rdata_d[RespThldLsb+:$bits(thld_t)] = resp_thld_q;
      end
      AddrResetCtrl: begin
        rdata_d[CmdRstBit]  = cmd_rst_q;
        rdata_d[RespRstBit] = resp_rst_q;
      end
      AddrQueueStatus: begin
        rdata_d[CmdDepthLsb+:$bits(cmd_depth_t)]   = cmd_depth_i;
        rdata_d[RespDepthLsb+:$bits(resp_depth_t)] = resp_depth_i;
      end
      default: rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= csr_req_i.we | csr_req_i.re;  // Writes are acknowledged too
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= csr_req_i.re ? rdata_d : '0;
  end

  assign csr_rsp_o = '{ack: ack_q, rdata: rdata_q};

endmodule

// File: logic/hci_pio.sv
// Top of the PIO queue block; joins the register port with the command and response queues
`timescale 1ns/10ps

module hci_pio (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  hci_pkg::csr_req_t    csr_req_i,
  output hci_pkg::csr_rsp_t    csr_rsp_o,
  output logic                 cmd_rvalid_o,
  input  logic                 cmd_ready_i,
  output hci_pkg::cmd_data_t   cmd_rdata_o,
  input  logic                 resp_wvalid_i,
  output logic                 resp_wready_o,
  input  hci_pkg::resp_data_t  resp_wdata_i,
  output logic                 cmd_thld_trig_o,
  output logic                 resp_thld_trig_o,
  output hci_pkg::cmd_depth_t  cmd_depth_o,
  output hci_pkg::resp_depth_t resp_depth_o
);

  import hci_pkg::*;

  logic       cmd_dword_wr;
  csr_data_t  cmd_dword;
  logic       resp_pop;
  resp_data_t resp_head;
  thld_t      cmd_thld;
  thld_t      resp_thld;
  logic       cmd_flush;
  logic       resp_flush;
  logic       cmd_flush_done;
  logic       resp_flush_done;

  hci_pio_regs regs_i (
    .clk_i,
    .rst_ni,
    .csr_req_i,
    .csr_rsp_o,
    .cmd_dword_wr_o   (cmd_dword_wr),
    .cmd_dword_o      (cmd_dword),
    .resp_pop_o       (resp_pop),
    .resp_head_i      (resp_head),
    .cmd_depth_i      (cmd_depth_o),
    .resp_depth_i     (resp_depth_o),
    .cmd_thld_o       (cmd_thld),
    .resp_thld_o      (resp_thld),
    .cmd_flush_o      (cmd_flush),
    .resp_flush_o     (resp_flush),
    .cmd_flush_done_i (cmd_flush_done),
    .resp_flush_done_i(resp_flush_done)
  );

  // Software to controller
  hci_cmd_queue cmd_queue_i (
    .clk_i,
    .rst_ni,
    .dword_wr_i  (cmd_dword_wr),
    .dword_i     (cmd_dword),
    .thld_i      (cmd_thld),
    .flush_i     (cmd_flush),
    .flush_done_o(cmd_flush_done),
    .rvalid_o    (cmd_rvalid_o),
    .ready_i     (cmd_ready_i),
    .rdata_o     (cmd_rdata_o),
    .depth_o     (cmd_depth_o),
    .thld_trig_o (cmd_thld_trig_o)
  );

  // Controller to software
  hci_resp_queue resp_queue_i (
    .clk_i,
    .rst_ni,
    .wvalid_i    (resp_wvalid_i),
    .wready_o    (resp_wready_o),
    .wdata_i     (resp_wdata_i),
    .pop_i       (resp_pop),
    .head_o      (resp_head),
    .thld_i      (resp_thld),
    .flush_i     (resp_flush),
    .flush_done_o(resp_flush_done),
    .depth_o     (resp_depth_o),
    .thld_trig_o (resp_thld_trig_o)
  );

endmodule

// File: tests/hci_pio_asserts.sv
// Concurrent checks bound into the PIO top; reset values, register handshake and queue resets
`timescale 1ns/10ps

module hci_pio_asserts (
  input logic                 clk_i,
  input logic                 rst_ni,
  input hci_pkg::csr_req_t    csr_req_i,
  input hci_pkg::csr_rsp_t    csr_rsp_i,
  input logic                 cmd_rvalid_i,
  input logic                 cmd_ready_i,
  input hci_pkg::cmd_data_t   cmd_rdata_i,
  input logic                 resp_wready_i,
  input logic                 cmd_trig_i,
  input logic                 resp_trig_i,
  input hci_pkg::cmd_depth_t  cmd_depth_i,
  input hci_pkg::resp_depth_t resp_depth_i,
  input logic                 cmd_flush_i,
  input logic                 resp_flush_i
);

  import hci_pkg::*;

  int unsigned err_count = 0;  // Polled by the testbench
  logic        idle_ok;
  logic        strobe;

  assign idle_ok = !csr_rsp_i.ack && !cmd_rvalid_i && cmd_depth_i == '0 && resp_depth_i == '0
                   && cmd_trig_i && !resp_trig_i && resp_wready_i;
  assign strobe  = csr_req_i.we || csr_req_i.re;

  // Held during reset and on the first cycle out of it
  reset_values_a: assert property (@(posedge clk_i) (!rst_ni || $rose(rst_ni)) |-> idle_ok)
    else begin $error("Reset values wrong"); err_count++; end

  ack_after_strobe_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    strobe |=> csr_rsp_i.ack)
    else begin $error("No ack one cycle after strobe"); err_count++; end

  no_spurious_ack_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !strobe |=> !csr_rsp_i.ack)
    else begin $error("Ack without strobe"); err_count++; end

  // Head held while the controller stalls, unless a flush hits
  cmd_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_rvalid_i && !cmd_ready_i && !cmd_flush_i |=> cmd_rvalid_i && $stable(cmd_rdata_i))
    else begin $error("Command head changed under stall"); err_count++; end

  resp_wready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_wready_i == (resp_depth_i != resp_depth_t'(RespDepth)))
    else begin $error("Response wready does not match full"); err_count++; end

  cmd_rst_clear_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cmd_flush_i) |=> cmd_flush_i ##1 !cmd_flush_i)
    else begin $error("Command reset bit did not self clear"); err_count++; end

  resp_rst_clear_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(resp_flush_i) |=> resp_flush_i ##1 !resp_flush_i)
    else begin $error("Response reset bit did not self clear"); err_count++; end

endmodule

// File: tests/hci_pio_tb.sv
// Testbench for the PIO queue block; random traffic on both queues checked against a queue model
`timescale 1ns/10ps

module hci_pio_tb;

  import hci_pkg::*;

  logic        clk_i;
  logic        rst_ni;
  csr_req_t    csr_req_i;
  csr_rsp_t    csr_rsp_o;
  logic        cmd_rvalid_o;
  logic        cmd_ready_i;
  cmd_data_t   cmd_rdata_o;
  logic        resp_wvalid_i;
  logic        resp_wready_o;
  resp_data_t  resp_wdata_i;
  logic        cmd_thld_trig_o;
  logic        resp_thld_trig_o;
  cmd_depth_t  cmd_depth_o;
  resp_depth_t resp_depth_o;

  cmd_data_t   cmd_q[$];    // Expected commands in order
  resp_data_t  resp_q[$];   // Responses accepted by the DUT
  int          resp_feed;   // Responses still to be offered
  int unsigned ready_mode;  // 0 low, 1 high, else random
  int unsigned cycles;
  logic [31:0] lfsr_state = 32'h97ec;
  logic [15:0] thld_list [4] = '{16'h0000, 16'h0503, 16'h1008, 16'h11c8};
  csr_data_t   rd;

  hci_pio hci_pio_i (.*);

  bind hci_pio hci_pio_asserts asserts_i (
    .clk_i, .rst_ni, .csr_req_i,
    .csr_rsp_i(csr_rsp_o), .cmd_rvalid_i(cmd_rvalid_o), .cmd_ready_i,
    .cmd_rdata_i(cmd_rdata_o), .resp_wready_i(resp_wready_o), .cmd_trig_i(cmd_thld_trig_o),
    .resp_trig_i(resp_thld_trig_o), .cmd_depth_i(cmd_depth_o), .resp_depth_i(resp_depth_o),
    .cmd_flush_i(cmd_flush), .resp_flush_i(resp_flush)
  );

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_bits(input int unsigned n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else fail_now($sformatf("ERR %s got %h exp %h", name, got, exp));
  endtask

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  // Strobe for one cycle and take the answer on the next
  task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
    csr_req_i = '{we: 1'b1, re: 1'b0, addr: addr, wdata: data};
    step();
    csr_req_i = '0;
    check_val("csr_rsp_o.ack", csr_rsp_o.ack, 1);
  endtask

  task automatic csr_read(input csr_addr_t addr, output csr_data_t data);
    csr_req_i = '{we: 1'b0, re: 1'b1, addr: addr, wdata: '0};
    step();
    csr_req_i = '0;
    check_val("csr_rsp_o.ack", csr_rsp_o.ack, 1);
    data = csr_rsp_o.rdata;
  endtask

  task automatic push_cmd_rand();
    csr_data_t lo;
    csr_data_t hi;
    lo = lfsr_bits(32);
    hi = lfsr_bits(32);
    csr_write(AddrCmdPort, lo);
    csr_write(AddrCmdPort, hi);
    if (cmd_q.size() < CmdDepth) cmd_q.push_back({hi, lo});  // Dropped when full
  endtask

  task automatic read_resp_check();
    csr_data_t got;
    csr_read(AddrRespPort, got);
    check_val("resp_port rdata", got, resp_q.pop_front());
  endtask

  task automatic check_triggers(input thld_t cmd_thld, input thld_t resp_thld);
    int unsigned cmd_eff;
    int unsigned resp_eff;
    cmd_eff  = (cmd_thld == 0) ? 1 : cmd_thld;
    resp_eff = (resp_thld == 0) ? 1 : resp_thld;
    check_val("cmd_depth_o", cmd_depth_o, cmd_q.size());
    check_val("resp_depth_o", resp_depth_o, resp_q.size());
    check_val("cmd_thld_trig_o", cmd_thld_trig_o, (CmdDepth - cmd_q.size()) >= cmd_eff);
    check_val("resp_thld_trig_o", resp_thld_trig_o, resp_q.size() >= resp_eff);
  endtask

  task automatic check_rst_bits(input csr_data_t bits);
    csr_data_t got;
    csr_read(AddrResetCtrl, got);
    check_val("reset_ctrl first", got, bits);
    csr_read(AddrResetCtrl, got);
    check_val("reset_ctrl second", got, bits);
    csr_read(AddrResetCtrl, got);
    check_val("reset_ctrl third", got, 0);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Controller side driven 1 ns after the edge
  always @(posedge clk_i) begin
    #1;
    case (ready_mode)
      0: cmd_ready_i = 1'b0;
      1: cmd_ready_i = 1'b1;
      default: cmd_ready_i = lfsr_bits(1) != 0;
    endcase
    if (resp_feed > 0) begin
      resp_wvalid_i = lfsr_bits(1) != 0;
      resp_wdata_i  = lfsr_bits(32);
    end else begin
      resp_wvalid_i = 1'b0;
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= 6000) fail_now("Run timed out before the tests finished");
    if (hci_pio_i.asserts_i.err_count != 0) fail_now("A concurrent assertion failed");
    if (rst_ni) begin
      if (cmd_rvalid_o && cmd_ready_i) begin
        if (cmd_q.size() == 0) fail_now("Command came out with none expected");
        check_val("cmd_rdata_o", cmd_rdata_o, cmd_q.pop_front());
      end
      if (resp_wvalid_i && resp_wready_o) begin
        resp_q.push_back(resp_wdata_i);
        resp_feed--;
      end
    end
  end

  initial begin
    rst_ni = 1'b1;
    csr_req_i = '0;
    cmd_ready_i = 1'b0;
    resp_wvalid_i = 1'b0;
    resp_wdata_i = '0;
    resp_feed = 0;
    ready_mode = 0;
    cycles = 0;
    #1 rst_ni = 1'b0;
    repeat (10) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    step();

    // Pairing and order under random ready
    ready_mode = 2;
    for (int i = 0; i < 20; i++) begin
      while (cmd_q.size() >= 6) step();
      push_cmd_rand();
    end
    while (cmd_q.size() != 0) step();

    // Empty read and then in-order responses
    csr_read(AddrRespPort, rd);
    check_val("resp_port empty read", rd, 0);
    resp_feed = 12;
    while (resp_feed != 0) step();
    while (resp_q.size() != 0) read_resp_check();

    // Response queue filled up and drained while more arrive
    resp_feed = 20;
    while (resp_q.size() < RespDepth) step();
    repeat (3) step();
    check_val("resp_wready_o", resp_wready_o, 0);
    check_val("resp_depth_o", resp_depth_o, RespDepth);
    while (resp_q.size() != 0 || resp_feed != 0) begin
      if (resp_q.size() != 0) read_resp_check();
      else step();
    end

    // Ninth command is dropped
    ready_mode = 0;
    for (int i = 0; i < 9; i++) push_cmd_rand();
    repeat (2) step();
    check_val("cmd_depth_o", cmd_depth_o, CmdDepth);
    ready_mode = 1;
    while (cmd_q.size() != 0) step();
    repeat (3) step();
    check_val("cmd_depth_o", cmd_depth_o, 0);

    // Threshold sweep over every fill level
    ready_mode = 0;
    for (int t = 0; t < 4; t++) begin
      csr_write(AddrThldCtrl, {16'h0, thld_list[t]});
      csr_read(AddrThldCtrl, rd);
      check_val("thld_ctrl", rd, {16'h0, thld_list[t]});
      csr_write(AddrResetCtrl, 32'h3);
      cmd_q.delete();
      resp_q.delete();
      repeat (3) step();
      for (int lvl = 0; lvl <= RespDepth; lvl++) begin
        check_triggers(thld_list[t][7:0], thld_list[t][15:8]);
        if (lvl < RespDepth) begin
          if (lvl < CmdDepth) push_cmd_rand();
          resp_feed = 1;
          while (resp_feed != 0) step();
          step();
        end
      end
    end
    csr_write(AddrResetCtrl, 32'h3);
    cmd_q.delete();
    resp_q.delete();
    repeat (3) step();

    // Command reset with a half-written pair pending
    for (int i = 0; i < 3; i++) push_cmd_rand();
    resp_feed = 5;
    while (resp_feed != 0) step();
    csr_write(AddrCmdPort, lfsr_bits(32));
    csr_write(AddrResetCtrl, 32'h1);
    cmd_q.delete();
    check_rst_bits(32'h1);
    csr_read(AddrQueueStatus, rd);
    check_val("queue_status", rd, 32'h0500);
    push_cmd_rand();
    ready_mode = 1;
    while (cmd_q.size() != 0) step();

    // Response reset leaves commands alone
    ready_mode = 0;
    push_cmd_rand();
    csr_write(AddrResetCtrl, 32'h2);
    resp_q.delete();
    check_rst_bits(32'h2);
    csr_read(AddrQueueStatus, rd);
    check_val("queue_status", rd, 32'h0001);
    ready_mode = 1;
    while (cmd_q.size() != 0) step();
    repeat (3) step();

    if (hci_pio_i.asserts_i.err_count != 0) begin
      fail_now("A concurrent assertion failed");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// File: hci_pio.f
logic/hci_pkg.sv
logic/hci_fifo.sv
logic/hci_cmd_queue.sv
logic/hci_resp_queue.sv
logic/hci_pio_regs.sv
logic/hci_pio.sv
tests/hci_pio_asserts.sv
tests/hci_pio_tb.sv
